// File: Makefile
# Verilator build and run for the tilemap testbench

VERILATOR ?= verilator
TOP       ?= tb_tilemap
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator status is ignored
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
common/tile_pkg.sv
src/video_timing.sv
src/dual_port_ram.sv
tilemap/tile_regs.sv
tilemap/tile_scan.sv
src/tile_irq.sv
src/tilemap_top.sv
dv/tilemap_asserts.sv
dv/tb_tilemap.sv

// File: common/tile_pkg.sv
// Tilemap shared package with frame limits, register map and bus types
package tile_pkg;

    // Register window 1C00-1FFF, bits 9:7 pick the register
    localparam logic [15:0] REG_BASE_HI = 16'h1C00;

    localparam logic [2:0] REG_CFG   = 3'd0; // 1C00 mapper and colour mode
    localparam logic [2:0] REG_SCR   = 3'd1; // 1C80 row/col scroll enables
    localparam logic [2:0] REG_INT   = 3'd2; // 1D00 interrupt enables
    localparam logic [2:0] REG_BANK0 = 3'd3; // 1D80
    localparam logic [2:0] REG_RMRD  = 3'd4; // 1E00 ROM read bank
    localparam logic [2:0] REG_FLIP  = 3'd5; // 1E80
    localparam logic [2:0] REG_BANK1 = 3'd6; // 1F00

    // Frame of 384 pixels by 264 lines
    localparam logic [8:0] H_START    = 9'h020;
    localparam logic [8:0] H_END      = 9'h19F;
    localparam logic [8:0] V_START    = 9'h0F8;
    localparam logic [8:0] V_END      = 9'h1FF;
    localparam logic [8:0] ROWSCR_END = 9'h04F; // Row scroll table read before this

    typedef struct packed {
        logic [1:0]  map_sel;     // CPU memory map
        logic        same_col_n;  // Low replaces colour bits 3:2 with bank bits
        logic        cscrb_en;
        logic        rscrb_en;
        logic        cscra_en;
        logic        rscra_en;
        logic [1:0]  fine_row;    // Per layer, high scrolls every line
        logic [2:0]  int_en;      // irq, firq, nmi
        logic [7:0]  bank0;
        logic [7:0]  bank1;
        logic [7:0]  rmrd_bank;
        logic        flip;
        logic        hflip_en;
        logic        vflip_en;
        logic [16:0] spare;
    } tile_cfg_t;

    // Scan port word, tile entry or scroll pair depending on phase
    typedef union packed {
        struct packed { logic [7:0] attr; logic [7:0] code; } tile;
        struct packed { logic [7:0] scr_hi; logic [7:0] scr_lo; } scr;
    } scan_word_u;

    typedef struct packed {
        logic [12:0] rom_addr;
        logic [7:0]  col;
    } layer_out_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       pxl_cen;
    } video_pos_t;

endpackage

// File: dv/tb_tilemap.sv
// Tilemap testbench, directed tests of registers, RAM map, layer outputs and interrupts
`timescale 1ns/1ps

module tb_tilemap;
    import tile_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int FRAME_PIX   = 384 * 264;
    localparam int TIMEOUT_CYC = FRAME_PIX * 2 * 5 / 2; // 2.5 frames of clocks

    logic        clk = 1'b0;
    logic        rst, gfx_cs, cpu_we, rmrd;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_dout, cpu_din, st_dout;
    logic [2:0]  debug_sel;
    logic        irq_n, firq_n, nmi_n, flip, hflip_en;
    layer_out_t  lyrf, lyra, lyrb;
    video_pos_t  pos;
    int          cyc_cnt = 0;

    tilemap_top u_dut (.*);

    always #(CLK_HALF) clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("Timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYC);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic step_clk();
        @(posedge clk);
        #1; // Drive and sample just after the edge
    endtask

    // Advance to the next cycle that carries a pixel enable
    task automatic next_pixel();
        step_clk();
        while (!pos.pxl_cen)
            step_clk();
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            report_failure();
        end
    endtask

    task automatic check_layer(input string name, input layer_out_t lyr,
                               input logic [12:0] rom, input logic [7:0] col);
        expect_eq({name, ".rom_addr"}, 32'(lyr.rom_addr), 32'(rom));
        expect_eq({name, ".col"}, 32'(lyr.col), 32'(col));
    endtask

    task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
        gfx_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        step_clk(); // Single cycle strobe
        gfx_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic read_bus(input logic [15:0] addr, output logic [7:0] data);
        gfx_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        step_clk();
        data   = cpu_din; // One clock of RAM latency
        gfx_cs = 1'b0;
    endtask

    task automatic set_reg(input logic [2:0] idx, input logic [7:0] data);
        write_bus(REG_BASE_HI | {6'd0, idx, 7'd0}, data); // Index on address bits 9:7
    endtask

    // Colour bank nibble {cab, colour bits 3:2} picked by attribute bits 3:2
    function automatic logic [3:0] bank_nibble(input logic [7:0] attr, input logic [7:0] b0,
                                               input logic [7:0] b1);
        case (attr[3:2])
            2'd0:    return b0[3:0];
            2'd1:    return b0[7:4];
            2'd2:    return b1[3:0];
            default: return b1[7:4];
        endcase
    endfunction

    // Line n lines later, wrapping at the bottom of the frame
    function automatic logic [8:0] line_ahead(input logic [8:0] v, input int n);
        for (int i = 0; i < n; i++)
            v = (v == V_END) ? V_START : v + 9'd1;
        return v;
    endfunction

    task automatic reg_readback_test();
        logic [7:0] vals [0:6];
        logic [7:0] inv;
        for (int i = 0; i < 7; i++) begin
            vals[i] = 8'($urandom);
            set_reg(3'(i), vals[i]);
        end
        for (int i = 0; i < 7; i++) begin
            debug_sel = 3'(i);
            step_clk(); // st_dout is registered
            expect_eq($sformatf("st_dout reg %0d", i), 32'(st_dout), 32'(vals[i]));
        end
        // Flip bits 0 and 1 leave the top level directly
        expect_eq("flip", 32'(flip), 32'(vals[REG_FLIP][0]));
        expect_eq("hflip_en", 32'(hflip_en), 32'(vals[REG_FLIP][1]));
        inv = ~vals[REG_FLIP];
        set_reg(REG_FLIP, inv);
        expect_eq("flip", 32'(flip), 32'(inv[0]));
        expect_eq("hflip_en", 32'(hflip_en), 32'(inv[1]));
        for (int i = 0; i < 7; i++)
            set_reg(3'(i), 8'h00);
    endtask

    task automatic ram_mapping_test();
        logic [12:0] offs  [0:7];
        logic [7:0]  a_dat [0:7];
        logic [7:0]  c_dat [0:7];
        logic [7:0]  rd;
        set_reg(REG_CFG, 8'h00);
        for (int i = 0; i < 8; i++) begin
            offs[i]  = {3'(i), 10'($urandom)}; // Top bits keep offsets distinct
            a_dat[i] = 8'($urandom);
            c_dat[i] = 8'($urandom);
            write_bus(16'hA000 | {3'b000, offs[i]}, a_dat[i]);
            write_bus(16'h6000 | {3'b000, offs[i]}, c_dat[i]);
        end
        for (int i = 0; i < 8; i++) begin
            read_bus(16'hA000 | {3'b000, offs[i]}, rd);
            expect_eq("cpu_din attr at A000", 32'(rd), 32'(a_dat[i]));
            read_bus(16'h6000 | {3'b000, offs[i]}, rd);
            expect_eq("cpu_din code at 6000", 32'(rd), 32'(c_dat[i]));
        end
        set_reg(REG_CFG, 8'h02);
        // Map 2 moves attr to 6000 and code to 2000
        for (int i = 0; i < 8; i++) begin
            read_bus(16'h6000 | {3'b000, offs[i]}, rd);
            expect_eq("cpu_din attr at 6000", 32'(rd), 32'(a_dat[i]));
            read_bus(16'h2000 | {3'b000, offs[i]}, rd);
            expect_eq("cpu_din code at 2000", 32'(rd), 32'(c_dat[i]));
        end
        set_reg(REG_CFG, 8'h00);
    endtask

    task automatic rom_read_test();
        logic [7:0]  bank;
        logic [15:0] addr;
        bank = 8'($urandom);
        set_reg(REG_BANK0, 8'h00);
        set_reg(REG_BANK1, 8'h00);
        set_reg(REG_RMRD, bank);
        rmrd = 1'b1;
        for (int n = 0; n < 2; n++) begin
            addr     = 16'($urandom);
            cpu_addr = addr;
            repeat (5) next_pixel(); // Each layer sees its phase at least once
            step_clk();
            check_layer("lyra", lyra, {2'b00, addr[12:2]}, bank);
            check_layer("lyrb", lyrb, {2'b00, addr[12:2]}, bank);
            check_layer("lyrf", lyrf, {2'b00, addr[12:2]}, bank);
        end
        rmrd     = 1'b0;
        cpu_addr = 16'h0000;
        set_reg(REG_RMRD, 8'h00);
    endtask

    task automatic fix_layer_test();
        logic [7:0]  b0, b1, attr, code, exp_col;
        logic [8:0]  tgt_v;
        logic [5:0]  col;
        logic [12:0] off;
        logic [3:0]  nib;
        b0 = 8'($urandom);
        b1 = 8'($urandom);
        set_reg(REG_SCR, 8'h00);
        set_reg(REG_FLIP, 8'h00);
        set_reg(REG_BANK0, b0);
        set_reg(REG_BANK1, b1);
        for (int k = 0; k < 2; k++) begin
            set_reg(REG_CFG, {2'b00, k[0], 5'b00000}); // same_col_n on bit 5
            attr  = 8'($urandom);
            code  = 8'($urandom);
            col   = 6'($urandom_range(11, 50));  // Past the row scroll reads
            tgt_v = line_ahead(pos.vdump, 2 + $urandom_range(0, 3));
            off   = {2'b00, tgt_v[7:3], col};   // Fix map cell
            write_bus(16'hA000 | {3'b000, off}, attr);
            write_bus(16'h6000 | {3'b000, off}, code);
            // Fix layer updated on phase 3, stable through phase 0
            while (!(pos.vdump == tgt_v && pos.hdump == {col, 3'b100}))
                step_clk();
            nib     = bank_nibble(attr, b0, b1);
            exp_col = (k != 0) ? attr : {attr[7:4], nib[1:0], attr[1:0]};
            check_layer("lyrf", lyrf, {nib[3:2], code, tgt_v[2:0]}, exp_col);
        end
        set_reg(REG_CFG, 8'h00);
        set_reg(REG_BANK0, 8'h00);
        set_reg(REG_BANK1, 8'h00);
    endtask

    task automatic interrupt_test();
        logic [8:0] v, last_v;
        logic       last_nmi;
        int         line_cnt, last_chg, n_chg;
        line_cnt = 0;
        last_chg = 0;
        n_chg    = 0;
        set_reg(REG_INT, 8'h07);
        repeat (2) next_pixel();
        step_clk();
        last_v   = pos.vdump;
        last_nmi = nmi_n;
        for (int p = 0; p < FRAME_PIX; p++) begin
            next_pixel();
            v = pos.vdump;
            if (v != last_v)
                line_cnt++;
            last_v = v;
            step_clk(); // Outputs registered on the pixel enable
            expect_eq("irq_n", 32'(irq_n), 32'(v == V_START));
            expect_eq("firq_n", 32'(firq_n), 32'(v[0]));
            if (nmi_n != last_nmi) begin
                if (n_chg > 0)
                    expect_eq("nmi_n change interval", 32'(line_cnt - last_chg), 32'd16);
                last_chg = line_cnt;
                last_nmi = nmi_n;
                n_chg++;
            end
        end
        expect_true(n_chg >= 16, "nmi_n toggled too few times during one frame");
        set_reg(REG_INT, 8'h00);
        repeat (2) next_pixel();
        step_clk();
        for (int p = 0; p < 40 * 384; p++) begin
            next_pixel();
            step_clk();
            expect_true(irq_n && firq_n && nmi_n, "an interrupt went low while disabled");
        end
    endtask

    initial begin
        rst       = 1'b1;
        gfx_cs    = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = 16'h0000;
        cpu_dout  = 8'h00;
        rmrd      = 1'b0;
        debug_sel = 3'd0;
        void'($urandom(32'h69f0_49d1));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        step_clk();
        reg_readback_test();
        ram_mapping_test();
        rom_read_test();
        fix_layer_test();
        interrupt_test();
        // Any failed check has already stopped the run
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: dv/tilemap_asserts.sv
// Tilemap top level checks on pixel enable, dump counter ranges and layer A timing
`timescale 1ns/1ps

module tilemap_asserts (
    input logic                 clk,
    input logic                 rst,
    input tile_pkg::video_pos_t pos,
    input tile_pkg::layer_out_t lyra
);
    import tile_pkg::*;

    // Pixel enable on every second clock, first cycle out of reset skipped
    cen_toggle: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> pos.pxl_cen != $past(pos.pxl_cen))
        else $error("pxl_cen did not alternate");

    dump_range: assert property (@(posedge clk) disable iff (rst)
        pos.hdump >= H_START && pos.hdump <= H_END && pos.vdump >= V_START)
        else $error("hdump or vdump left the frame");

    // Layer A only moves on a pixel enable
    lyra_hold: assert property (@(posedge clk) disable iff (rst)
        !pos.pxl_cen |=> lyra == $past(lyra))
        else $error("lyra changed between pixel enables");

endmodule

bind tilemap_top tilemap_asserts u_asserts (.clk(clk), .rst(rst), .pos(pos), .lyra(lyra));

// File: src/dual_port_ram.sv
// Dual port RAM, CPU read/write port and read-only scan port
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int AW = 13
) (
    input  logic          clk,
    input  logic [AW-1:0] cpu_addr,
    input  logic [7:0]    cpu_data,
    input  logic          cpu_we,
    output logic [7:0]    cpu_q,
    input  logic [AW-1:0] scan_addr,
    output logic [7:0]    scan_q
);

    logic [7:0] mem [0:(2**AW)-1];

    always_ff @(posedge clk) begin
        if (cpu_we)
            mem[cpu_addr] <= cpu_data;
        cpu_q  <= mem[cpu_addr];  // Old data on a write cycle
        scan_q <= mem[scan_addr]; // Scan side never writes
    end

endmodule

// File: src/tile_irq.sv
// Tilemap interrupt generator for frame, two-line and line-group interrupts
`timescale 1ns/1ps

module tile_irq (
    input  logic                 clk,
    input  logic                 rst,
    input  tile_pkg::video_pos_t pos,
    input  tile_pkg::tile_cfg_t  cfg,
    output logic                 irq_n,
    output logic                 firq_n,
    output logic                 nmi_n
);
    import tile_pkg::*;

    logic       v4_l;   // Previous vdump bit 2
    logic [1:0] v8;     // Counts 8-line groups
    logic       v4_rise;

    assign v4_rise = pos.vdump[2] & ~v4_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v4_l   <= 1'b0;
            v8     <= 2'd0;
            irq_n  <= 1'b0;
            firq_n <= 1'b0;
            nmi_n  <= 1'b0;
        end else if (pos.pxl_cen) begin
            v4_l <= pos.vdump[2];
            if (v4_rise)
                v8 <= v8 + 2'd1;
            // Once per frame, released on the first line
            irq_n  <= (pos.vdump == V_START) | ~cfg.int_en[2];
            firq_n <= pos.vdump[0] | ~cfg.int_en[1]; // Every other line
            nmi_n  <= v8[1] | ~cfg.int_en[0];        // Toggles each 16 lines
        end
    end

endmodule

// File: src/tilemap_top.sv
// Tilemap subsystem top, timing, registers, tile RAMs, scanner and interrupts
`timescale 1ns/1ps

module tilemap_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 gfx_cs,
    input  logic                 cpu_we,
    input  logic [15:0]          cpu_addr,
    input  logic [7:0]           cpu_dout,
    output logic [7:0]           cpu_din,
    input  logic                 rmrd,
    output logic                 irq_n,
    output logic                 firq_n,
    output logic                 nmi_n,
    output logic                 flip,
    output logic                 hflip_en,
    output tile_pkg::layer_out_t lyrf,
    output tile_pkg::layer_out_t lyra,
    output tile_pkg::layer_out_t lyrb,
    output tile_pkg::video_pos_t pos,
    input  logic [2:0]           debug_sel,
    output logic [7:0]           st_dout
);
    import tile_pkg::*;

    tile_cfg_t  cfg;
    scan_word_u scan_dout;  // Attr RAM on the high byte
    logic [12:0] scan_addr;
    logic [7:0]  attr_q, code_q;
    logic        attr_we, code_we;

    assign flip     = cfg.flip;
    assign hflip_en = cfg.hflip_en;

    video_timing u_timing (.clk(clk), .rst(rst), .pos(pos));

    tile_regs u_regs (
        .clk(clk), .rst(rst), .gfx_cs(gfx_cs), .cpu_we(cpu_we),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .attr_q(attr_q), .code_q(code_q),
        .cpu_din(cpu_din), .attr_we(attr_we), .code_we(code_we), .cfg(cfg),
        .debug_sel(debug_sel), .st_dout(st_dout)
    );

    dual_port_ram #(.AW(13)) u_attr (
        .clk(clk), .cpu_addr(cpu_addr[12:0]), .cpu_data(cpu_dout), .cpu_we(attr_we),
        .cpu_q(attr_q), .scan_addr(scan_addr), .scan_q(scan_dout[15:8])
    );

    dual_port_ram #(.AW(13)) u_code (
        .clk(clk), .cpu_addr(cpu_addr[12:0]), .cpu_data(cpu_dout), .cpu_we(code_we),
        .cpu_q(code_q), .scan_addr(scan_addr), .scan_q(scan_dout[7:0])
    );

    tile_scan u_scan (
        .clk(clk), .rst(rst), .pos(pos), .cfg(cfg), .rmrd(rmrd), .cpu_addr(cpu_addr),
        .scan_addr(scan_addr), .scan_dout(scan_dout),
        .lyrf(lyrf), .lyra(lyra), .lyrb(lyrb)
    );

    tile_irq u_irq (
        .clk(clk), .rst(rst), .pos(pos), .cfg(cfg),
        .irq_n(irq_n), .firq_n(firq_n), .nmi_n(nmi_n)
    );

endmodule

// File: src/video_timing.sv
// Video timing, pixel enable plus horizontal and vertical dump counters
`timescale 1ns/1ps

module video_timing (
    input  logic                 clk,
    input  logic                 rst,
    output tile_pkg::video_pos_t pos
);
    import tile_pkg::*;

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic       cen;

    assign pos = {hdump, vdump, cen};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen   <= 1'b0;
            hdump <= H_START;
            vdump <= V_START;
        end else begin
            cen <= ~cen; // Half clock pixel rate
            if (cen) begin
                if (hdump == H_END) begin
                    hdump <= H_START;
                    // Next line, wraps to the top of the frame
                    if (vdump == V_END)
                        vdump <= V_START;
                    else
                        vdump <= vdump + 9'd1;
                end else begin
                    hdump <= hdump + 9'd1;
                end
            end
        end
    end

endmodule

// File: tilemap/tile_regs.sv
// Tilemap CPU interface, memory mapper, control registers and debug readback
`timescale 1ns/1ps

module tile_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                gfx_cs,
    input  logic                cpu_we,
    input  logic [15:0]         cpu_addr,
    input  logic [7:0]          cpu_dout,
    input  logic [7:0]          attr_q,
    input  logic [7:0]          code_q,
    output logic [7:0]          cpu_din,
    output logic                attr_we,
    output logic                code_we,
    output tile_pkg::tile_cfg_t cfg,
    input  logic [2:0]          debug_sel,
    output logic [7:0]          st_dout
);
    import tile_pkg::*;

    logic [7:0] mmr [0:6];
    logic [2:0] page;     // 8 kB window index
    logic       attr_cs, code_cs, attr_sel, reg_we;

    assign page    = cpu_addr[15:13];
    // Attr at A000 down to 4000, code at 6000 down to 0000
    assign attr_cs = page == (3'd5 - {1'b0, mmr[REG_CFG][1:0]});
    assign code_cs = page == (3'd3 - {1'b0, mmr[REG_CFG][1:0]});
    assign attr_we = gfx_cs & cpu_we & attr_cs;
    assign code_we = gfx_cs & cpu_we & code_cs;
    assign reg_we  = gfx_cs & cpu_we & (cpu_addr[15:10] == REG_BASE_HI[15:10])
                   & (cpu_addr[9:7] != 3'd7); // Index 7 is unused
    assign cpu_din = attr_sel ? attr_q : code_q; // Follows the RAM read latency

    always_comb begin
        cfg            = '0;
        cfg.map_sel    = mmr[REG_CFG][1:0];
        cfg.same_col_n = mmr[REG_CFG][5];
        {cfg.cscrb_en, cfg.rscrb_en, cfg.fine_row[1],
         cfg.cscra_en, cfg.rscra_en, cfg.fine_row[0]} = mmr[REG_SCR][5:0];
        cfg.int_en     = mmr[REG_INT][2:0];
        cfg.bank0      = mmr[REG_BANK0];
        cfg.bank1      = mmr[REG_BANK1];
        cfg.rmrd_bank  = mmr[REG_RMRD];
        cfg.flip       = mmr[REG_FLIP][0];
        cfg.hflip_en   = mmr[REG_FLIP][1];
        cfg.vflip_en   = mmr[REG_FLIP][2];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 7; i++)
                mmr[i] <= 8'd0;
            attr_sel <= 1'b0;
            st_dout  <= 8'd0;
        end else begin
            if (reg_we)
                mmr[cpu_addr[9:7]] <= cpu_dout;
            attr_sel <= attr_cs;
            st_dout  <= (debug_sel == 3'd7) ? 8'd0 : mmr[debug_sel];
        end
    end

endmodule

// File: tilemap/tile_scan.sv
// Tilemap scanner, scroll latching, scan addressing and layer ROM addresses
`timescale 1ns/1ps

module tile_scan (
    input  logic                 clk,
    input  logic                 rst,
    input  tile_pkg::video_pos_t pos,
    input  tile_pkg::tile_cfg_t  cfg,
    input  logic                 rmrd,
    input  logic [15:0]          cpu_addr,
    output logic [12:0]          scan_addr,
    input  tile_pkg::scan_word_u scan_dout,
    output tile_pkg::layer_out_t lyrf,
    output tile_pkg::layer_out_t lyra,
    output tile_pkg::layer_out_t lyrb
);
    import tile_pkg::*;

    logic [8:0]  hdumpf, flipk, hposa, hposb, hsum_a, hsum_b;
    logic [7:0]  vposa, vposb, col_cfg;
    logic [10:0] map_a, map_b, vc;
    logic [2:0]  vsub_a, vsub_b, vmux;
    logic [1:0]  cab, col_aux;
    logic [12:0] addr_nx;
    logic        rowscr_rd, row_data, upd_en, rd_vpos, rd_hpos, vflip;
    layer_out_t  lyr_nx;

    assign hdumpf    = pos.hdump ^ {9{cfg.flip}};
    assign flipk     = {{6{cfg.flip}}, 1'b0, {2{cfg.flip}}}; // Flipped screen offset
    assign rowscr_rd = pos.hdump < ROWSCR_END;
    // Scan data trails the address by one pixel
    assign row_data  = (pos.hdump > H_START) && (pos.hdump <= ROWSCR_END);
    assign upd_en    = (pos.hdump > ROWSCR_END) || rmrd;
    assign rd_vpos   = pos.hdump[8:3] == 6'h0C; // Column scroll forced once per line
    assign rd_hpos   = pos.vdump[7:0] == 8'd0;  // Row scroll forced on line 0

    // Scan address for the next pixel
    always_comb begin
        hsum_a = hdumpf + flipk + hposa;
        hsum_b = hdumpf + flipk + hposb;
        map_a[5:0] = hsum_a[8:3];
        map_b[5:0] = hsum_b[8:3];
        {map_a[10:6], vsub_a} = pos.vdump[7:0] + vposa;
        {map_b[10:6], vsub_b} = pos.vdump[7:0] + vposb;
        if (rowscr_rd) begin
            // Table at 1A00, one entry per line or per 8 lines
            addr_nx = {4'b1101, pos.vdump[7:3],
                       pos.vdump[2:0] & {3{cfg.fine_row[pos.hdump[1]]}}, pos.hdump[0]};
        end else begin
            case (pos.hdump[1:0])
                2'd0:    addr_nx = {2'b01, map_a};                      // Map A
                2'd1:    addr_nx = {2'b10, map_b};                      // Map B
                2'd2:    addr_nx = {2'b00, pos.vdump[7:3], pos.hdump[8:3]}; // Fix
                default: addr_nx = {7'b1100000, hdumpf[8:3] + {6{cfg.flip}}};
            endcase
        end
    end

    // ROM address and colour from the tile entry
    always_comb begin
        case (scan_dout.tile.attr[3:2])
            2'd0:    {cab, col_aux} = cfg.bank0[3:0];
            2'd1:    {cab, col_aux} = cfg.bank0[7:4];
            2'd2:    {cab, col_aux} = cfg.bank1[3:0];
            default: {cab, col_aux} = cfg.bank1[7:4];
        endcase
        col_cfg = scan_dout.tile.attr;
        if (!cfg.same_col_n)
            col_cfg[3:2] = col_aux;
        case (pos.hdump[1:0])
            2'd1:    vmux = vsub_a;
            2'd2:    vmux = vsub_b;
            default: vmux = pos.vdump[2:0]; // Fix layer never scrolls
        endcase
        vflip = scan_dout.tile.attr[1] & cfg.vflip_en;
        vc    = {scan_dout.tile.code, vmux ^ {3{vflip}}};
        if (rmrd) begin
            col_cfg = cfg.rmrd_bank; // CPU peeks at the tile ROM
            vc      = cpu_addr[12:2];
        end
        lyr_nx.rom_addr = {cab, vc};
        lyr_nx.col      = col_cfg;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_addr <= 13'd0;
            hposa     <= 9'd0;
            hposb     <= 9'd0;
            vposa     <= 8'd0;
            vposb     <= 8'd0;
            lyrf      <= '0;
            lyra      <= '0;
            lyrb      <= '0;
        end else begin
            scan_addr <= addr_nx;
            if (pos.pxl_cen) begin
                if (upd_en) begin
                    case (pos.hdump[1:0])
                        2'd0: begin // Column scroll pair
                            if (!rmrd && (rd_vpos || cfg.cscra_en))
                                vposa <= scan_dout.scr.scr_hi;
                            if (!rmrd && (rd_vpos || cfg.cscrb_en))
                                vposb <= scan_dout.scr.scr_lo;
                        end
                        2'd1:    lyra <= lyr_nx;
                        2'd2:    lyrb <= lyr_nx;
                        default: lyrf <= lyr_nx;
                    endcase
                end
            end else if (row_data) begin
                // Row scroll words, A from attr RAM and B from code RAM
                case (pos.hdump[1:0])
                    2'd1: if (rd_hpos || cfg.rscra_en) hposa[7:0] <= scan_dout.scr.scr_hi;
                    2'd2: if (rd_hpos || cfg.rscra_en) hposa[8]   <= scan_dout.scr.scr_hi[0];
                    2'd3: if (rd_hpos || cfg.rscrb_en) hposb[7:0] <= scan_dout.scr.scr_lo;
                    default: if (rd_hpos || cfg.rscrb_en) hposb[8] <= scan_dout.scr.scr_lo[0];
                endcase
            end
        end
    end

endmodule
